// File: sources.f
hdl/rx_regs_pkg.sv
hdl/rx_sample_pkg.sv
hdl/apb_settings.sv
hdl/rx_frontend.sv
hdl/rx_dsp_chan.sv
hdl/rx_framer.sv
hdl/u2_rx_top.sv
testbench/rx_stream_properties.sv
testbench/tb_u2_rx_top.sv

// File: Bender.yml
package:
  name: u2_rx_core

sources:
  - files:
      - hdl/rx_regs_pkg.sv
      - hdl/rx_sample_pkg.sv
      - hdl/apb_settings.sv
      - hdl/rx_frontend.sv
      - hdl/rx_dsp_chan.sv
      - hdl/rx_framer.sv
      - hdl/u2_rx_top.sv
  - target: test
    files:
      - testbench/rx_stream_properties.sv
      - testbench/tb_u2_rx_top.sv

// File: testbench/tb_u2_rx_top.sv
// Testbench for the receive core
// Random ramp stimulus, APB register traffic and a reference model
// of the front end, channels and framer that checks every output word
module tb_u2_rx_top import rx_regs_pkg::*, rx_sample_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          N_CHAN     = 2;
   localparam int          FIFO_DEPTH = 16;
   localparam int          FRAME_LEN  = 8;
   localparam int          ROUNDS     = 6;
   localparam logic [31:0] SEED       = 32'h469c1160;
   // About four times the summed worst case of all tests
   localparam int          MAX_CYCLES = 20000;

   logic             dsp_clk = 1'b0;
   logic             por_rst;
   logic [7:0]       paddr_i;
   logic             psel_i;
   logic             penable_i;
   logic             pwrite_i;
   logic [31:0]      pwdata_i;
   logic [31:0]      prdata_o;
   logic             pready_o;
   logic             pslverr_o;
   logic [ADC_W-1:0] adc_a_i;
   logic [ADC_W-1:0] adc_b_i;
   rx_word_u         out_data_o;
   logic             out_valid_o;
   logic             out_ready_i;

   // Reference model state
   logic [15:0] dc_a_m;
   logic [15:0] dc_b_m;
   logic        swap_m;
   int          decim_m [N_CHAN];
   logic [11:0] exp_seq [N_CHAN];
   int          frames_left [N_CHAN];
   logic        cont_m [N_CHAN];
   logic        have_prev [N_CHAN];
   logic [15:0] prev_a [N_CHAN];
   int          mon_beat;
   int          mon_ch;
   logic        hold_ready;
   int          cycles;

   u2_rx_top #(.N_CHAN(N_CHAN), .FIFO_DEPTH(FIFO_DEPTH), .FRAME_LEN(FRAME_LEN)) dut (.*);

   always #5 dsp_clk = ~dsp_clk;

   // Ramp on adc_a, complement on adc_b, random back-pressure
   always @(posedge dsp_clk) begin
      #1;
      adc_a_i     = adc_a_i + 1'b1;
      adc_b_i     = ~adc_a_i;
      out_ready_i = hold_ready ? 1'b0 : (($urandom % 10) < 7);
   end

   always @(posedge dsp_clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Run timed out after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Checking and bus tasks

   task automatic check_eq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
         $display("TEST RESULT: FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // Setup cycle then access cycle, no wait states
   task automatic apb_access(input logic write, input set_addr_t word,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      @(posedge dsp_clk);
      #1;
      paddr_i   = {word, 2'b00};
      pwdata_i  = wdata;
      pwrite_i  = write;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      @(posedge dsp_clk);
      #1;
      penable_i = 1'b1;
      @(negedge dsp_clk);
      check_eq("pready_o", 1, pready_o);
      rdata = prdata_o;
      err   = pslverr_o;
      @(posedge dsp_clk);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic reg_write(input set_addr_t word, input logic [31:0] data);
      logic [31:0] unused;
      logic        err;
      apb_access(1'b1, word, data, unused, err);
      check_eq("pslverr_o on write", 0, err);
   endtask

   task automatic reg_read(input set_addr_t word, output logic [31:0] data);
      logic err;
      apb_access(1'b0, word, 32'd0, data, err);
      check_eq("pslverr_o on read", 0, err);
   endtask

   function automatic set_addr_t chan_word(input int ch, input int off);
      return set_addr_t'(REG_CHAN_BASE + ch * CHAN_STRIDE + off);
   endfunction

   task automatic set_frontend(input logic [15:0] dc_a, input logic [15:0] dc_b,
                               input logic swap);
      logic [31:0] rd;
      dc_a_m = dc_a;
      dc_b_m = dc_b;
      swap_m = swap;
      reg_write(REG_DC_A, {16'd0, dc_a});
      reg_write(REG_DC_B, {16'd0, dc_b});
      reg_write(REG_SWAP_IQ, {31'd0, swap});
      reg_read(REG_DC_A, rd);
      check_eq("dc_a readback", {16'd0, dc_a}, rd);
      reg_read(REG_DC_B, rd);
      check_eq("dc_b readback", {16'd0, dc_b}, rd);
      reg_read(REG_SWAP_IQ, rd);
      check_eq("swap readback", {31'd0, swap}, rd);
   endtask

   task automatic start_counted(input int ch, input int d, input int nfr);
      decim_m[ch]     = d;
      have_prev[ch]   = 1'b0;
      cont_m[ch]      = 1'b0;
      frames_left[ch] = nfr;
      reg_write(chan_word(ch, CH_DECIM), d);
      reg_write(chan_word(ch, CH_CMD), nfr * FRAME_LEN);
   endtask

   task automatic wait_frames_done();
      logic busy;
      busy = 1'b1;
      while (busy) begin
         @(posedge dsp_clk);
         busy = 1'b0;
         for (int c = 0; c < N_CHAN; c++)
            if (frames_left[c] != 0)
               busy = 1'b1;
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Output stream monitor

   // Inputs change 1 ns after the rising edge, so the falling edge
   // sees what the next rising edge transfers
   always @(negedge dsp_clk) begin : monitor
      rx_word_u    w;
      logic [15:0] a_part;
      int          ch;
      if (!por_rst && out_valid_o && out_ready_i) begin
         w = out_data_o;
         if (mon_beat == 0) begin
            ch = int'(w.hdr.chan);
            check_eq("hdr.magic", HDR_MAGIC, w.hdr.magic);
            check_eq("hdr.chan below N_CHAN", 1, ch < N_CHAN);
            check_eq("hdr.len", FRAME_LEN, w.hdr.len);
            check_eq("hdr.seq", exp_seq[ch], w.hdr.seq);
            check_eq("frame pending on hdr.chan", 1, cont_m[ch] || frames_left[ch] != 0);
            exp_seq[ch] = exp_seq[ch] + 12'd1;
            mon_ch      = ch;
            mon_beat    = 1;
         end else begin
            // Both paths share the ramp, so the sum is fixed
            check_eq("iq.i + iq.q + dc_a + dc_b", 16'hFFFC,
                     16'(w.iq.i + w.iq.q + dc_a_m + dc_b_m));
            a_part = swap_m ? 16'(w.iq.q + dc_a_m) : 16'(w.iq.i + dc_a_m);
            if (have_prev[mon_ch])
               check_eq("iq step", 16'(prev_a[mon_ch] + 4 * decim_m[mon_ch]), a_part);
            have_prev[mon_ch] = 1'b1;
            prev_a[mon_ch]    = a_part;
            if (mon_beat == FRAME_LEN) begin
               mon_beat = 0;
               if (!cont_m[mon_ch])
                  frames_left[mon_ch] = frames_left[mon_ch] - 1;
            end else begin
               mon_beat = mon_beat + 1;
            end
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin : main
      logic [31:0] rd;
      logic [31:0] cmd;
      logic        err;
      int          c;
      int          d;
      void'($urandom(SEED));
      por_rst     = 1'b1;
      paddr_i     = '0;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
      pwdata_i    = '0;
      out_ready_i = 1'b0;
      hold_ready  = 1'b0;
      cycles      = 0;
      mon_beat    = 0;
      mon_ch      = 0;
      dc_a_m      = '0;
      dc_b_m      = '0;
      swap_m      = 1'b0;
      for (int k = 0; k < N_CHAN; k++) begin
         decim_m[k]     = 1;
         exp_seq[k]     = '0;
         frames_left[k] = 0;
         cont_m[k]      = 1'b0;
         have_prev[k]   = 1'b0;
         prev_a[k]      = '0;
      end
      adc_a_i = ADC_W'($urandom);
      adc_b_i = ~adc_a_i;
      repeat (3) @(posedge dsp_clk);
      #1;
      por_rst = 1'b0;

      // Register map
      reg_read(REG_STATUS, rd);
      check_eq("status after reset", 0, rd);
      reg_read(REG_COMPAT, rd);
      check_eq("compat", COMPAT_NUM, rd);
      apb_access(1'b1, REG_COMPAT, 32'h1234_5678, rd, err);
      check_eq("pslverr_o on compat write", 1, err);
      set_frontend(16'($urandom), 16'($urandom), 1'b1);
      for (int k = 0; k < N_CHAN; k++) begin
         // Count 0 without the continuous flag keeps the channel idle
         cmd = {1'b0, 15'($urandom), 16'd0};
         d   = 1 + $urandom % 6;
         reg_write(chan_word(k, CH_DECIM), d);
         reg_read(chan_word(k, CH_DECIM), rd);
         check_eq("decim readback", d, rd);
         reg_write(chan_word(k, CH_CMD), cmd);
         reg_read(chan_word(k, CH_CMD), rd);
         check_eq("cmd readback", cmd, rd);
      end

      // Counted streams on all channels at once
      for (int r = 0; r < ROUNDS; r++) begin
         set_frontend(16'($urandom), 16'($urandom), 1'($urandom % 2));
         for (int k = 0; k < N_CHAN; k++)
            start_counted(k, 1 + $urandom % 6, 1 + $urandom % (FIFO_DEPTH / FRAME_LEN));
         wait_frames_done();
         reg_read(REG_STATUS, rd);
         check_eq("status after counted streams", 0, rd);
         repeat (40) @(posedge dsp_clk);
      end

      // Overrun under a stalled output
      c          = $urandom % N_CHAN;
      hold_ready = 1'b1;
      repeat (2) @(posedge dsp_clk);
      decim_m[c]   = 1 + $urandom % 3;
      have_prev[c] = 1'b0;
      cont_m[c]    = 1'b1;
      reg_write(chan_word(c, CH_DECIM), decim_m[c]);
      reg_write(chan_word(c, CH_CMD), 32'h8000_0000);
      rd = '0;
      while (rd[8 + c] == 1'b0)
         reg_read(REG_STATUS, rd);
      check_eq("status at overrun", 32'd1 << (8 + c), rd);
      // A full FIFO holds exactly this many frames
      cont_m[c]      = 1'b0;
      frames_left[c] = FIFO_DEPTH / FRAME_LEN;
      hold_ready     = 1'b0;
      wait_frames_done();
      repeat (40) @(posedge dsp_clk);
      reg_read(REG_STATUS, rd);
      check_eq("sticky overrun", 32'd1 << (8 + c), rd);
      reg_write(chan_word(c, CH_CLEAR), 32'd1);
      exp_seq[c] = '0;
      reg_read(REG_STATUS, rd);
      check_eq("status after clear", 0, rd);
      start_counted(c, 1 + $urandom % 6, FIFO_DEPTH / FRAME_LEN);
      wait_frames_done();
      reg_read(REG_STATUS, rd);
      check_eq("status after restart", 0, rd);
      repeat (20) @(posedge dsp_clk);

      if (dut.u_framer.u_props.fail_cnt != 0) begin
         $display("Stream assertions failed %0d times", dut.u_framer.u_props.fail_cnt);
         $display("TEST RESULT: FAIL");
         $fatal(1, "assertion failures");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

// File: testbench/rx_stream_properties.sv
// Output stream properties of the framer
// Stall stability, pops only from channels that hold the rest of the
// frame and frames that stay on one channel from header to last sample
module rx_stream_properties import rx_sample_pkg::*; #(
   parameter int N_CHAN    = 2,
   parameter int FRAME_LEN = 8
) (
   input logic                  dsp_clk,
   input logic                  por_rst,
   input logic [FIFO_CNT_W-1:0] count_i [N_CHAN],
   input logic [N_CHAN-1:0]     pop_i,
   input rx_word_u              data_i,
   input logic                  valid_i,
   input logic                  ready_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_cnt = 0;
   int          beat;
   int          frame_ch;
   int          pops;

   // Position in the frame, 0 is the header slot
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         beat     <= 0;
         frame_ch <= 0;
      end else if (valid_i && ready_i) begin
         if (beat == 0)
            frame_ch <= int'(data_i.hdr.chan);
         beat <= (beat == FRAME_LEN) ? 0 : beat + 1;
      end
   end

   // Samples already taken from the FIFO for the current frame
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         pops <= 0;
      else if (pop_i != '0)
         pops <= (pops == FRAME_LEN - 1) ? 0 : pops + 1;
   end

   a_stall_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      valid_i && !ready_i |=> valid_i && $stable(data_i))
   else begin
      $error("output word changed while stalled");
      fail_cnt++;
   end

   a_hdr_slot: assert property (@(posedge dsp_clk) disable iff (por_rst)
      valid_i && ready_i && beat == 0 |->
         data_i.hdr.magic == HDR_MAGIC && data_i.hdr.len == FRAME_LEN)
   else begin
      $error("frame start without a header");
      fail_cnt++;
   end

   // Inside a frame only the framed channel is drained
   a_one_chan: assert property (@(posedge dsp_clk) disable iff (por_rst)
      beat != 0 && pop_i != '0 |-> pop_i == (1 << frame_ch))
   else begin
      $error("frame interleaved with another channel");
      fail_cnt++;
   end

   // Whatever the frame still needs is already buffered
   for (genvar c = 0; c < N_CHAN; c++) begin : g_pop
      a_pop_backed: assert property (@(posedge dsp_clk) disable iff (por_rst)
         pop_i[c] |-> count_i[c] >= FRAME_LEN - pops)
      else begin
         $error("pop on a channel FIFO that cannot finish the frame");
         fail_cnt++;
      end
   end

endmodule

bind rx_framer rx_stream_properties #(.N_CHAN(N_CHAN), .FRAME_LEN(FRAME_LEN)) u_props (
   .dsp_clk(dsp_clk), .por_rst(por_rst), .count_i(fifo_count_i), .pop_i(pop_o),
   .data_i(out_data_o), .valid_i(out_valid_o), .ready_i(out_ready_i)
);

// File: hdl/u2_rx_top.sv
// Receive core top level
// APB settings slave, ADC front end, receive channels and the
// framer that drains them onto one output stream
module u2_rx_top import rx_regs_pkg::*, rx_sample_pkg::*; #(
   parameter int N_CHAN     = 2,
   parameter int FIFO_DEPTH = 16,
   parameter int FRAME_LEN  = 8
) (
   input  logic             dsp_clk,
   input  logic             por_rst,
   input  logic [7:0]       paddr_i,
   input  logic             psel_i,
   input  logic             penable_i,
   input  logic             pwrite_i,
   input  logic [31:0]      pwdata_i,
   output logic [31:0]      prdata_o,
   output logic             pready_o,
   output logic             pslverr_o,
   input  logic [ADC_W-1:0] adc_a_i,
   input  logic [ADC_W-1:0] adc_b_i,
   output rx_word_u         out_data_o,
   output logic             out_valid_o,
   input  logic             out_ready_i
);

   logic                  set_stb;
   set_addr_t             set_addr;
   logic [31:0]           set_data;
   iq_sample_t            fe_sample;
   logic [FIFO_CNT_W-1:0] fifo_count [N_CHAN];
   iq_sample_t            head_sample [N_CHAN];
   logic [N_CHAN-1:0]     pop;
   logic [N_CHAN-1:0]     running;
   logic [N_CHAN-1:0]     overrun;

   apb_settings #(.N_CHAN(N_CHAN)) u_apb (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
      .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
      .pready_o(pready_o), .pslverr_o(pslverr_o),
      .running_i(running), .overrun_i(overrun),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data)
   );

   rx_frontend u_frontend (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .adc_a_i(adc_a_i), .adc_b_i(adc_b_i), .fe_sample_o(fe_sample)
   );

   // Every channel sees the same front-end stream
   for (genvar g = 0; g < N_CHAN; g++) begin : g_chan
      rx_dsp_chan #(.CHAN_ID(g), .FIFO_DEPTH(FIFO_DEPTH)) u_chan (
         .dsp_clk(dsp_clk), .por_rst(por_rst),
         .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
         .fe_sample_i(fe_sample), .pop_i(pop[g]),
         .head_sample_o(head_sample[g]), .fifo_count_o(fifo_count[g]),
         .running_o(running[g]), .overrun_o(overrun[g])
      );
   end

   rx_framer #(.N_CHAN(N_CHAN), .FRAME_LEN(FRAME_LEN)) u_framer (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr),
      .fifo_count_i(fifo_count), .head_sample_i(head_sample), .pop_o(pop),
      .out_data_o(out_data_o), .out_valid_o(out_valid_o), .out_ready_i(out_ready_i)
   );

endmodule

// File: hdl/rx_framer.sv
// Round-robin framer
// Picks the next channel holding a full frame, sends a header and
// then FRAME_LEN samples of that channel on a valid/ready stream
module rx_framer import rx_regs_pkg::*, rx_sample_pkg::*; #(
   parameter int N_CHAN    = 2,
   parameter int FRAME_LEN = 8
) (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic                  set_stb_i,
   input  set_addr_t             set_addr_i,
   input  logic [FIFO_CNT_W-1:0] fifo_count_i [N_CHAN],
   input  iq_sample_t            head_sample_i [N_CHAN],
   output logic [N_CHAN-1:0]     pop_o,
   output rx_word_u              out_data_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i
);

   localparam int CH_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

   logic              in_frame;
   logic [CH_W-1:0]   cur_ch;
   logic [CH_W-1:0]   last_ch;
   logic [CH_W-1:0]   pick;
   logic              pick_ok;
   logic [7:0]        left;
   logic              load;
   logic              pop_now;
   logic [N_CHAN-1:0] clr_hit;
   logic [11:0]       seq_cnt [N_CHAN];
   frame_hdr_t        hdr;

   // Output register is free or being drained
   assign load = !out_valid_o || out_ready_i;

   always_comb begin
      for (int c = 0; c < N_CHAN; c++)
         clr_hit[c] = set_stb_i && set_addr_i == chan_addr(c, CH_CLEAR);
   end

   // Search starts one past the channel served last
   always_comb begin : rr_pick
      int idx;
      pick    = last_ch;
      pick_ok = 1'b0;
      for (int k = 1; k <= N_CHAN; k++) begin
         idx = int'(last_ch) + k;
         if (idx >= N_CHAN)
            idx = idx - N_CHAN;
         if (!pick_ok && fifo_count_i[idx] >= FRAME_LEN && !clr_hit[idx]) begin
            pick    = CH_W'(idx);
            pick_ok = 1'b1;
         end
      end
   end

   assign hdr.magic = HDR_MAGIC;
   assign hdr.chan  = 4'(pick);
   assign hdr.seq   = seq_cnt[pick];
   assign hdr.len   = 8'(FRAME_LEN);

   assign pop_now = in_frame && load && fifo_count_i[cur_ch] != '0;

   always_comb begin
      pop_o         = '0;
      pop_o[cur_ch] = pop_now;
   end

   ///////////////////////////////////////////////////////////////////////
   // Frame sequencing

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         in_frame    <= 1'b0;
         out_valid_o <= 1'b0;
         cur_ch      <= '0;
         last_ch     <= CH_W'(N_CHAN - 1);
         left        <= '0;
      end else if (load) begin
         if (in_frame) begin
            out_valid_o <= pop_now;
            if (pop_now) begin
               left <= left - 8'd1;
               if (left == 8'd1) begin
                  in_frame <= 1'b0;
                  last_ch  <= cur_ch;
               end
            end
         end else begin
            out_valid_o <= pick_ok;
            if (pick_ok) begin
               in_frame <= 1'b1;
               cur_ch   <= pick;
               left     <= 8'(FRAME_LEN);
            end
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (load) begin
         if (in_frame)
            out_data_o.iq <= head_sample_i[cur_ch];
         else
            out_data_o.hdr <= hdr;
      end
   end

   // Per-channel frame numbers, restart on a channel clear
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         for (int c = 0; c < N_CHAN; c++)
            seq_cnt[c] <= '0;
      end else begin
         for (int c = 0; c < N_CHAN; c++) begin
            if (clr_hit[c])
               seq_cnt[c] <= '0;
            else if (load && !in_frame && pick_ok && pick == c)
               seq_cnt[c] <= seq_cnt[c] + 12'd1;
         end
      end
   end

endmodule

// File: hdl/rx_dsp_chan.sv
// One receive channel
// Decimates the front-end stream, runs counted or continuous stream
// commands and buffers samples for the framer, with sticky overrun
module rx_dsp_chan import rx_regs_pkg::*, rx_sample_pkg::*; #(
   parameter int CHAN_ID    = 0,
   parameter int FIFO_DEPTH = 16
) (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic                  set_stb_i,
   input  set_addr_t             set_addr_i,
   input  logic [31:0]           set_data_i,
   input  iq_sample_t            fe_sample_i,
   input  logic                  pop_i,
   output iq_sample_t            head_sample_o,
   output logic [FIFO_CNT_W-1:0] fifo_count_o,
   output logic                  running_o,
   output logic                  overrun_o
);

   localparam int AW = $clog2(FIFO_DEPTH);

   logic        decim_wr;
   logic        cmd_wr;
   logic        clear_wr;
   logic [15:0] decim;
   logic [15:0] dec_cnt;
   logic [15:0] remain;
   logic        cont;
   logic        take;
   logic        full;
   logic        push;
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic [AW:0] used;
   iq_sample_t  mem [FIFO_DEPTH];

   assign decim_wr = set_stb_i && set_addr_i == chan_addr(CHAN_ID, CH_DECIM);
   assign cmd_wr   = set_stb_i && set_addr_i == chan_addr(CHAN_ID, CH_CMD);
   assign clear_wr = set_stb_i && set_addr_i == chan_addr(CHAN_ID, CH_CLEAR);

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         decim <= 16'd1;
      else if (decim_wr)
         decim <= set_data_i[15:0];
   end

   ///////////////////////////////////////////////////////////////////////
   // Stream control

   // Sample point of the decimator
   assign take = running_o && dec_cnt == '0;
   assign push = take && !full && !cmd_wr && !clear_wr;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         dec_cnt   <= '0;
         remain    <= '0;
         cont      <= 1'b0;
         running_o <= 1'b0;
         overrun_o <= 1'b0;
      end else if (clear_wr) begin
         running_o <= 1'b0;
         overrun_o <= 1'b0;
      end else if (cmd_wr) begin
         cont      <= set_data_i[CMD_CONT_BIT];
         remain    <= set_data_i[15:0];
         dec_cnt   <= '0;
         running_o <= set_data_i[CMD_CONT_BIT] || set_data_i[15:0] != '0;
      end else if (take) begin
         // Decimation of 0 behaves as 1
         dec_cnt <= (decim == '0) ? '0 : decim - 16'd1;
         if (full) begin
            overrun_o <= 1'b1;
            running_o <= 1'b0;
         end else if (!cont) begin
            remain <= remain - 16'd1;
            if (remain == 16'd1)
               running_o <= 1'b0;
         end
      end else if (running_o) begin
         dec_cnt <= dec_cnt - 16'd1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Sample FIFO

   assign used = wr_ptr - rd_ptr;
   // Fill never exceeds the depth, so the top bit alone means full
   assign full          = used[AW];
   assign fifo_count_o  = FIFO_CNT_W'(used);
   assign head_sample_o = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_wr) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (push)
         mem[wr_ptr[AW-1:0]] <= fe_sample_i;
   end

endmodule

// File: hdl/rx_frontend.sv
// ADC front end
// Scales both ADC words to 16 bits, removes DC offsets and
// optionally swaps I and Q. Output is registered every cycle
module rx_frontend import rx_regs_pkg::*, rx_sample_pkg::*; (
   input  logic             dsp_clk,
   input  logic             por_rst,
   input  logic             set_stb_i,
   input  set_addr_t        set_addr_i,
   input  logic [31:0]      set_data_i,
   input  logic [ADC_W-1:0] adc_a_i,
   input  logic [ADC_W-1:0] adc_b_i,
   output iq_sample_t       fe_sample_o
);

   logic [SAMPLE_W-1:0] dc_a;
   logic [SAMPLE_W-1:0] dc_b;
   logic                swap;
   logic [SAMPLE_W-1:0] a_scaled;
   logic [SAMPLE_W-1:0] b_scaled;
   logic [SAMPLE_W-1:0] a_corr;
   logic [SAMPLE_W-1:0] b_corr;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         dc_a <= '0;
         dc_b <= '0;
         swap <= 1'b0;
      end else if (set_stb_i) begin
         if (set_addr_i == REG_DC_A)
            dc_a <= set_data_i[SAMPLE_W-1:0];
         if (set_addr_i == REG_DC_B)
            dc_b <= set_data_i[SAMPLE_W-1:0];
         if (set_addr_i == REG_SWAP_IQ)
            swap <= set_data_i[0];
      end
   end

   // Sign extend then x4, wraps modulo 2^16
   assign a_scaled = {{(SAMPLE_W-ADC_W){adc_a_i[ADC_W-1]}}, adc_a_i} << 2;
   assign b_scaled = {{(SAMPLE_W-ADC_W){adc_b_i[ADC_W-1]}}, adc_b_i} << 2;

   assign a_corr = a_scaled - dc_a;
   assign b_corr = b_scaled - dc_b;

   always_ff @(posedge dsp_clk) begin
      fe_sample_o.i <= swap ? b_corr : a_corr;
      fe_sample_o.q <= swap ? a_corr : b_corr;
   end

endmodule

// File: hdl/apb_settings.sv
// APB slave of the receive core
// Writes become settings bus strobes one cycle after the access
// cycle. Holds shadow copies for readback plus compat and status
module apb_settings import rx_regs_pkg::*; #(
   parameter int N_CHAN = 2
) (
   input  logic              dsp_clk,
   input  logic              por_rst,
   input  logic [7:0]        paddr_i,
   input  logic              psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [31:0]       pwdata_i,
   output logic [31:0]       prdata_o,
   output logic              pready_o,
   output logic              pslverr_o,
   input  logic [N_CHAN-1:0] running_i,
   input  logic [N_CHAN-1:0] overrun_i,
   output logic              set_stb_o,
   output set_addr_t         set_addr_o,
   output logic [31:0]       set_data_o
);

   set_addr_t   word;
   set_addr_t   ch_rel;
   int unsigned ch_idx;
   int unsigned ch_off;
   logic        ch_hit;
   logic        wr_ok;
   logic        wr_acc;
   logic [31:0] status_w;
   logic [15:0] dc_a_sh;
   logic [15:0] dc_b_sh;
   logic        swap_sh;
   logic [15:0] decim_sh [N_CHAN];
   logic [31:0] cmd_sh [N_CHAN];

   ///////////////////////////////////////////////////////////////////////
   // Address decode

   assign word   = paddr_i[7:2];
   assign ch_rel = word - REG_CHAN_BASE;
   assign ch_idx = ch_rel / CHAN_STRIDE;
   assign ch_off = ch_rel % CHAN_STRIDE;
   assign ch_hit = (word >= REG_CHAN_BASE) && (ch_idx < N_CHAN);

   always_comb begin
      wr_ok = 1'b0;
      if (word == REG_DC_A || word == REG_DC_B || word == REG_SWAP_IQ)
         wr_ok = 1'b1;
      else if (ch_hit && (ch_off == CH_DECIM || ch_off == CH_CMD || ch_off == CH_CLEAR))
         wr_ok = 1'b1;
   end

   // No wait states
   assign wr_acc    = psel_i & penable_i & pwrite_i;
   assign pready_o  = psel_i;
   assign pslverr_o = wr_acc & ~wr_ok;

   ///////////////////////////////////////////////////////////////////////
   // Readback

   always_comb begin
      status_w = '0;
      status_w[STAT_RUN_LSB +: N_CHAN] = running_i;
      status_w[STAT_OVR_LSB +: N_CHAN] = overrun_i;
   end

   always_comb begin
      prdata_o = '0;
      case (word)
         REG_DC_A:    prdata_o = {16'd0, dc_a_sh};
         REG_DC_B:    prdata_o = {16'd0, dc_b_sh};
         REG_SWAP_IQ: prdata_o = {31'd0, swap_sh};
         REG_COMPAT:  prdata_o = COMPAT_NUM;
         REG_STATUS:  prdata_o = status_w;
         default: begin
            if (ch_hit && ch_off == CH_DECIM)
               prdata_o = {16'd0, decim_sh[ch_idx]};
            else if (ch_hit && ch_off == CH_CMD)
               prdata_o = cmd_sh[ch_idx];
         end
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // Strobe and shadow registers

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_stb_o <= 1'b0;
         dc_a_sh   <= '0;
         dc_b_sh   <= '0;
         swap_sh   <= 1'b0;
         for (int c = 0; c < N_CHAN; c++) begin
            decim_sh[c] <= 16'd1;
            cmd_sh[c]   <= '0;
         end
      end else begin
         set_stb_o <= wr_acc & wr_ok;
         if (wr_acc && wr_ok) begin
            case (word)
               REG_DC_A:    dc_a_sh <= pwdata_i[15:0];
               REG_DC_B:    dc_b_sh <= pwdata_i[15:0];
               REG_SWAP_IQ: swap_sh <= pwdata_i[0];
               default: begin
                  if (ch_off == CH_DECIM)
                     decim_sh[ch_idx] <= pwdata_i[15:0];
                  if (ch_off == CH_CMD)
                     cmd_sh[ch_idx] <= pwdata_i;
               end
            endcase
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (wr_acc && wr_ok) begin
         set_addr_o <= word;
         set_data_o <= pwdata_i;
      end
   end

endmodule

// File: hdl/rx_sample_pkg.sv
// Receive sample formats
// I/Q sample layout, the frame header and the output word that
// carries either one of them
package rx_sample_pkg;

   localparam int SAMPLE_W = 16;
   localparam int ADC_W    = 14;

   // Width of the FIFO fill level toward the framer
   localparam int FIFO_CNT_W = 8;

   localparam logic [7:0] HDR_MAGIC = 8'hA5;

   typedef struct packed {
      logic [SAMPLE_W-1:0] i;
      logic [SAMPLE_W-1:0] q;
   } iq_sample_t;

   typedef struct packed {
      logic [7:0]  magic;
      logic [3:0]  chan;
      logic [11:0] seq;
      logic [7:0]  len;
   } frame_hdr_t;

   // First word of a frame is a header, the rest are samples
   typedef union packed {
      frame_hdr_t hdr;
      iq_sample_t iq;
   } rx_word_u;

endpackage

// File: hdl/rx_regs_pkg.sv
// Receive core register map
// Settings bus word addresses, the compatibility word and the
// layout of the status readback word
package rx_regs_pkg;

   typedef logic [5:0] set_addr_t;

   // Front end settings
   localparam set_addr_t REG_DC_A    = 6'd0;
   localparam set_addr_t REG_DC_B    = 6'd1;
   localparam set_addr_t REG_SWAP_IQ = 6'd2;

   // Readback only
   localparam set_addr_t REG_COMPAT = 6'd3;
   localparam set_addr_t REG_STATUS = 6'd4;

   // One block of words per receive channel
   localparam set_addr_t REG_CHAN_BASE = 6'd8;
   localparam int        CHAN_STRIDE   = 4;
   localparam int        CH_DECIM      = 0;
   localparam int        CH_CMD        = 1;
   localparam int        CH_CLEAR      = 2;

   // Continuous flag in the command word, count sits in [15:0]
   localparam int CMD_CONT_BIT = 31;

   // Major 7, minor 0
   localparam logic [31:0] COMPAT_NUM = {16'd7, 16'd0};

   // Status word fields
   localparam int STAT_RUN_LSB = 0;
   localparam int STAT_OVR_LSB = 8;

   function automatic set_addr_t chan_addr(input int ch, input int off);
      return set_addr_t'(REG_CHAN_BASE + ch * CHAN_STRIDE + off);
   endfunction

endpackage
